// ==== Makefile ====
TOP := exe_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" sim.log; then \
		echo "FAIL: run ended early"; exit 1; \
	else \
		echo "PASS"; \
	fi

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir sim.log

// ==== rtl/exe_arith.sv ====
`timescale 1ns/10ps

`include "exe_macros.svh"

module exe_arith (
    input  logic [`EXE_DATA_WIDTH-1:0] src_a,
    input  logic [`EXE_DATA_WIDTH-1:0] src_b,
    input  exe_pkg::arith_fn_e         fn,
    output logic [`EXE_DATA_WIDTH-1:0] result
);

    localparam int W = `EXE_DATA_WIDTH;

    logic         subtract;
    logic [W-1:0] b_in;
    logic [W-1:0] sum;
    logic         carry;
    logic         overflow;
    logic         less_signed;
    logic         less_unsigned;

    // Compares reuse the subtractor
    assign subtract = (fn == exe_pkg::FN_SUB) ||
                      (fn == exe_pkg::FN_SLT) ||
                      (fn == exe_pkg::FN_SLTU);

    assign b_in         = subtract ? ~src_b : src_b;
    assign {carry, sum} = {1'b0, src_a} + {1'b0, b_in} + {{W{1'b0}}, subtract};

    // Same input signs, different result sign
    assign overflow = (src_a[W-1] == b_in[W-1]) && (sum[W-1] != src_a[W-1]);

    assign less_signed   = sum[W-1] ^ overflow;
    assign less_unsigned = ~carry;      // No carry out means a borrow

    always_comb begin
        case (fn)
            exe_pkg::FN_ADD,
            exe_pkg::FN_SUB: begin
                result = sum;
            end
            exe_pkg::FN_AND:  result = src_a & src_b;
            exe_pkg::FN_OR:   result = src_a | src_b;
            exe_pkg::FN_XOR:  result = src_a ^ src_b;
            exe_pkg::FN_NOR:  result = ~(src_a | src_b);
            exe_pkg::FN_SLT:  result = {{(W-1){1'b0}}, less_signed};
            exe_pkg::FN_SLTU: result = {{(W-1){1'b0}}, less_unsigned};
            default: begin
                result = sum;
            end
        endcase
    end

endmodule

// ==== rtl/exe_macros.svh ====
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// Operand and result width
`define EXE_DATA_WIDTH  32

// Shift amount wide enough for 0 to DATA_WIDTH-1
`define EXE_SHIFT_WIDTH 5

// Request tag carried through to the response
`define EXE_TAG_WIDTH   4

`endif

// ==== rtl/exe_op_decode.sv ====
`timescale 1ns/10ps

module exe_op_decode (
    input  exe_pkg::exe_op_e    op,
    output logic                sel_shift,
    output exe_pkg::arith_fn_e  fn,
    output exe_pkg::shift_ctl_t ctl
);

    always_comb begin
        // Arithmetic add unless the opcode says otherwise
        sel_shift = 1'b0;
        fn        = exe_pkg::FN_ADD;
        ctl       = '0;

        case (op)
            exe_pkg::OP_ADD:  fn = exe_pkg::FN_ADD;
            exe_pkg::OP_SUB:  fn = exe_pkg::FN_SUB;
            exe_pkg::OP_AND:  fn = exe_pkg::FN_AND;
            exe_pkg::OP_OR:   fn = exe_pkg::FN_OR;
            exe_pkg::OP_XOR:  fn = exe_pkg::FN_XOR;
            exe_pkg::OP_NOR:  fn = exe_pkg::FN_NOR;
            exe_pkg::OP_SLT:  fn = exe_pkg::FN_SLT;
            exe_pkg::OP_SLTU: fn = exe_pkg::FN_SLTU;

            exe_pkg::OP_SLL: begin
                sel_shift = 1'b1;
                ctl.left  = 1'b1;
            end
            exe_pkg::OP_SRL: begin
                sel_shift = 1'b1;           // Logical right is all zero control
            end
            exe_pkg::OP_SRA: begin
                sel_shift      = 1'b1;
                ctl.arithmetic = 1'b1;
            end
            exe_pkg::OP_ROTR: begin
                sel_shift    = 1'b1;
                ctl.rotation = 1'b1;
            end
            exe_pkg::OP_ROTL: begin
                sel_shift    = 1'b1;
                ctl.rotation = 1'b1;
                ctl.left     = 1'b1;
            end

            // Signed amounts go right when positive and left when negative
            exe_pkg::OP_SHV: begin
                sel_shift        = 1'b1;
                ctl.shift_signed = 1'b1;
            end
            exe_pkg::OP_SHAV: begin
                sel_shift        = 1'b1;
                ctl.shift_signed = 1'b1;
                ctl.arithmetic   = 1'b1;
            end
            exe_pkg::OP_ROTV: begin
                sel_shift        = 1'b1;
                ctl.shift_signed = 1'b1;
                ctl.rotation     = 1'b1;
            end

            default: begin
                fn = exe_pkg::FN_ADD;       // Unknown code still gives a defined sum
            end
        endcase
    end

endmodule

// ==== rtl/exe_pkg.sv ====
`include "exe_macros.svh"

package exe_pkg;

    // Operation codes seen by the execute unit
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_NOR  = 4'h5,
        OP_SLT  = 4'h6,
        OP_SLTU = 4'h7,
        OP_SLL  = 4'h8,
        OP_SRL  = 4'h9,
        OP_SRA  = 4'ha,
        OP_ROTR = 4'hb,
        OP_ROTL = 4'hc,
        OP_SHV  = 4'hd,    // Signed amount, logical
        OP_SHAV = 4'he,    // Signed amount, arithmetic
        OP_ROTV = 4'hf     // Signed amount, rotate
    } exe_op_e;

    // Arithmetic block function
    typedef enum logic [2:0] {
        FN_ADD  = 3'd0,
        FN_SUB  = 3'd1,
        FN_AND  = 3'd2,
        FN_OR   = 3'd3,
        FN_XOR  = 3'd4,
        FN_NOR  = 3'd5,
        FN_SLT  = 3'd6,
        FN_SLTU = 3'd7
    } arith_fn_e;

    typedef struct packed {
        logic left;          // Left direction for a non-negative amount
        logic rotation;
        logic arithmetic;    // Sign fill on right shifts
        logic shift_signed;  // Amount is two's complement
    } shift_ctl_t;

    typedef struct packed {
        exe_op_e                     op;
        logic [`EXE_DATA_WIDTH-1:0]  src_a;
        logic [`EXE_DATA_WIDTH-1:0]  src_b;
        logic [`EXE_SHIFT_WIDTH-1:0] shamt;
        logic [`EXE_TAG_WIDTH-1:0]   tag;
    } exe_req_t;

    typedef struct packed {
        logic [`EXE_DATA_WIDTH-1:0] result;
        logic [`EXE_TAG_WIDTH-1:0]  tag;
    } exe_rsp_t;

endpackage

// ==== rtl/exe_shift.sv ====
`timescale 1ns/10ps

`include "exe_macros.svh"

module exe_shift #(
    parameter int SHIFT_WIDTH = `EXE_SHIFT_WIDTH,
    parameter int DATA_WIDTH  = `EXE_DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]  din,
    input  logic [SHIFT_WIDTH-1:0] shift,
    input  exe_pkg::shift_ctl_t    ctl,
    output logic [DATA_WIDTH-1:0]  dout
);

    // Copies of the word needed so the largest amount still wraps cleanly
    localparam int ROT_NUM   = ((1 << SHIFT_WIDTH) + 2 * DATA_WIDTH - 1) / DATA_WIDTH;
    localparam int ROT_SHIFT = (ROT_NUM - 1) * DATA_WIDTH;
    localparam int ROT_WIDTH = ROT_NUM * DATA_WIDTH;

    logic                   negative;
    logic [SHIFT_WIDTH-1:0] magnitude;
    logic                   go_left;
    logic [ROT_WIDTH-1:0]   rot_data;
    logic [ROT_WIDTH-1:0]   rot_right;
    logic [ROT_WIDTH-1:0]   rot_left;

    // Only a signed amount can be negative
    assign negative  = ctl.shift_signed & shift[SHIFT_WIDTH-1];
    assign magnitude = negative ? (~shift + 1'b1) : shift;  // Most negative value still fits
    assign go_left   = ctl.left ^ negative;                 // Negative flips direction

    // Rotates are plain shifts of the replicated word
    assign rot_data  = {ROT_NUM{din}};
    assign rot_right = rot_data >> magnitude;
    assign rot_left  = (rot_data << magnitude) >> ROT_SHIFT;

    always_comb begin
        case ({ctl.rotation, go_left, ctl.arithmetic})
            3'b000: begin
                dout = din >> magnitude;
            end
            3'b001: begin
                dout = $signed(din) >>> magnitude;          // Sign fill
            end
            3'b010,
            3'b011: begin
                dout = din << magnitude;                    // Zero fill either way
            end
            3'b100,
            3'b101: begin
                dout = rot_right[DATA_WIDTH-1:0];
            end
            default: begin
                dout = rot_left[DATA_WIDTH-1:0];
            end
        endcase
    end

endmodule

// ==== rtl/exe_unit.sv ====
`timescale 1ns/10ps

`include "exe_macros.svh"

module exe_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              cke,
    input  exe_pkg::exe_req_t req,
    input  logic              in_valid,
    output exe_pkg::exe_rsp_t rsp,
    output logic              out_valid
);

    exe_pkg::exe_req_t          req_q;      // Stage 1 request
    logic                       valid_q;
    logic                       sel_shift;
    exe_pkg::arith_fn_e         fn;
    exe_pkg::shift_ctl_t        ctl;
    logic [`EXE_DATA_WIDTH-1:0] arith_result;
    logic [`EXE_DATA_WIDTH-1:0] shift_result;
    logic [`EXE_DATA_WIDTH-1:0] result;

    // Stage 1 valid holds while cke is low
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (cke) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke && in_valid) begin
            req_q <= req;
        end
    end

    exe_op_decode u_decode (
        .op        (req_q.op),
        .sel_shift (sel_shift),
        .fn        (fn),
        .ctl       (ctl)
    );

    exe_arith u_arith (
        .src_a  (req_q.src_a),
        .src_b  (req_q.src_b),
        .fn     (fn),
        .result (arith_result)
    );

    // Shifter works on operand A only
    exe_shift #(
        .SHIFT_WIDTH (`EXE_SHIFT_WIDTH),
        .DATA_WIDTH  (`EXE_DATA_WIDTH)
    ) u_shift (
        .din   (req_q.src_a),
        .shift (req_q.shamt),
        .ctl   (ctl),
        .dout  (shift_result)
    );

    assign result = sel_shift ? shift_result : arith_result;

    // Stage 2 response register
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            rsp       <= '0;
        end else if (cke) begin
            out_valid <= valid_q;
            if (valid_q) begin
                rsp.result <= result;
                rsp.tag    <= req_q.tag;    // Tag rides along unchanged
            end
        end
    end

endmodule

// ==== sim/exe_unit_properties.sv ====
`timescale 1ns/10ps

module exe_unit_properties (
    input logic              clk,
    input logic              reset,
    input logic              cke,
    input logic              in_valid,
    input logic              stage_valid,
    input exe_pkg::exe_rsp_t rsp,
    input logic              out_valid
);

    int fail_count = 0;

    // Output stage empty after any reset edge
    reset_clears_output: assert property (@(posedge clk)
        reset |=> !out_valid && (rsp == '0))
        else begin
            fail_count++;
            $error("out_valid or rsp not cleared by reset");
        end

    // Whole pipeline frozen while cke is low
    stall_holds_state: assert property (@(posedge clk) disable iff (reset)
        !cke |=> $stable(rsp) && $stable(out_valid) && $stable(stage_valid))
        else begin
            fail_count++;
            $error("pipeline state moved while cke was low");
        end

    // Two enabled edges from request to response
    request_enters_stage: assert property (@(posedge clk) disable iff (reset)
        cke && in_valid |=> stage_valid)
        else begin
            fail_count++;
            $error("accepted request missing from stage 1");
        end

    stage_reaches_output: assert property (@(posedge clk) disable iff (reset)
        cke && stage_valid |=> out_valid)
        else begin
            fail_count++;
            $error("stage 1 request did not reach out_valid");
        end

    no_spurious_output: assert property (@(posedge clk) disable iff (reset)
        cke && !stage_valid |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid raised without a request");
        end

endmodule

bind exe_unit exe_unit_properties u_properties (
    .clk         (clk),
    .reset       (reset),
    .cke         (cke),
    .in_valid    (in_valid),
    .stage_valid (valid_q),
    .rsp         (rsp),
    .out_valid   (out_valid)
);

// ==== sim/exe_unit_tb.sv ====
`timescale 1ns/10ps

`include "exe_macros.svh"

module exe_unit_tb;

    localparam int          W           = `EXE_DATA_WIDTH;
    localparam int          CYCLE_LIMIT = 4000;  // Tests need about 700 cycles
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic              clk;
    logic              reset;
    logic              cke;
    logic              in_valid;
    exe_pkg::exe_req_t req;
    exe_pkg::exe_rsp_t rsp;
    logic              out_valid;

    exe_pkg::exe_rsp_t         expect_q[$];  // Responses still owed by the DUT
    logic [31:0]               lfsr_state;
    logic [`EXE_TAG_WIDTH-1:0] next_tag;
    int                        error_count = 0;
    int                        check_count = 0;
    int                        rsp_count   = 0;
    int                        cycle_count = 0;

    exe_unit dut (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .req       (req),
        .in_valid  (in_valid),
        .rsp       (rsp),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [W-1:0] rot_right(input logic [W-1:0] a, input int k);
        return (k == 0) ? a : ((a >> k) | (a << (W - k)));
    endfunction

    function automatic logic [W-1:0] rot_left(input logic [W-1:0] a, input int k);
        return (k == 0) ? a : ((a << k) | (a >> (W - k)));
    endfunction

    function automatic logic [W-1:0] sign_fill_right(input logic [W-1:0] a, input int k);
        logic [W-1:0] res;
        res = a >> k;
        if (a[W-1] && k > 0)
            res = res | ~({W{1'b1}} >> k);  // Copy sign into vacated bits
        return res;
    endfunction

    // Reference model of the execute unit
    function automatic exe_pkg::exe_rsp_t expected_rsp(input exe_pkg::exe_req_t r);
        exe_pkg::exe_rsp_t res;
        logic [W-1:0]      a;
        logic [W-1:0]      b;
        logic              neg;
        int                n;
        int                mag;
        a   = r.src_a;
        b   = r.src_b;
        n   = int'(r.shamt);
        neg = r.shamt[`EXE_SHIFT_WIDTH-1];
        mag = neg ? (32 - n) : n;           // Magnitude of a signed amount
        res.tag = r.tag;
        case (r.op)
            exe_pkg::OP_ADD:  res.result = a + b;
            exe_pkg::OP_SUB:  res.result = a - b;
            exe_pkg::OP_AND:  res.result = a & b;
            exe_pkg::OP_OR:   res.result = a | b;
            exe_pkg::OP_XOR:  res.result = a ^ b;
            exe_pkg::OP_NOR:  res.result = ~(a | b);
            exe_pkg::OP_SLT:  res.result = ($signed(a) < $signed(b)) ? 1 : 0;
            exe_pkg::OP_SLTU: res.result = (a < b) ? 1 : 0;
            exe_pkg::OP_SLL:  res.result = a << n;
            exe_pkg::OP_SRL:  res.result = a >> n;
            exe_pkg::OP_SRA:  res.result = sign_fill_right(a, n);
            exe_pkg::OP_ROTR: res.result = rot_right(a, n);
            exe_pkg::OP_ROTL: res.result = rot_left(a, n);
            exe_pkg::OP_SHV:  res.result = neg ? (a << mag) : (a >> mag);
            exe_pkg::OP_SHAV: res.result = neg ? (a << mag) : sign_fill_right(a, mag);
            default:          res.result = neg ? rot_left(a, mag) : rot_right(a, mag);
        endcase
        return res;
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    task automatic check_value(input string what, input logic [W-1:0] actual,
                               input logic [W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Mid-cycle monitor counts each response once before the enabled edge that replaces it
    always @(negedge clk) begin : monitor
        exe_pkg::exe_rsp_t exp_rsp;
        if (!reset && cke && out_valid) begin
            if (expect_q.size() == 0) begin
                error_count++;
                $display("Response with tag %0h arrived with no request outstanding at %0t",
                         rsp.tag, $time);
            end else begin
                exp_rsp = expect_q.pop_front();
                check_value("tag", W'(rsp.tag), W'(exp_rsp.tag));
                check_value("result", rsp.result, exp_rsp.result);
                rsp_count++;
            end
        end
        if (!reset && cke && in_valid)
            expect_q.push_back(expected_rsp(req));
    end

    task automatic issue(input exe_pkg::exe_op_e op, input logic [W-1:0] a,
                         input logic [W-1:0] b, input logic [4:0] shamt);
        req.op    = op;
        req.src_a = a;
        req.src_b = b;
        req.shamt = shamt;
        req.tag   = next_tag;
        in_valid  = 1'b1;
        cke       = 1'b1;
        next_tag++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain;
        int waited;
        cke    = 1'b1;
        waited = 0;
        while (expect_q.size() != 0 && waited < 4) begin
            idle_cycles(1);
            waited++;
        end
        if (expect_q.size() != 0) begin
            error_count++;
            $display("%0d expected responses never came out of the DUT", expect_q.size());
            expect_q.delete();
        end
        idle_cycles(2);  // Catch any stray extra response
    endtask

    task automatic test_reset;
        check_value("out_valid after reset", W'(out_valid), '0);
        check_value("rsp.result after reset", rsp.result, '0);
        check_value("rsp.tag after reset", W'(rsp.tag), '0);
    endtask

    task automatic test_arith;
        issue(exe_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd0);  // Signed wrap
        issue(exe_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0001, 5'd0);
        issue(exe_pkg::OP_SUB, 32'h0000_0000, 32'h0000_0001, 5'd0);
        issue(exe_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001, 5'd0);
        issue(exe_pkg::OP_SUB, 32'h1234_5678, 32'h1234_5678, 5'd0);
        issue(exe_pkg::OP_AND, 32'hf0f0_a5a5, 32'h0ff0_5a5a, 5'd0);
        issue(exe_pkg::OP_OR,  32'hf0f0_a5a5, 32'h0ff0_5a5a, 5'd0);
        issue(exe_pkg::OP_XOR, 32'hf0f0_a5a5, 32'h0ff0_5a5a, 5'd0);
        issue(exe_pkg::OP_NOR, 32'hf0f0_a5a5, 32'h0ff0_5a5a, 5'd0);
        issue(exe_pkg::OP_SLT,  32'hffff_ffff, 32'h0000_0001, 5'd0);  // -1 < 1 signed only
        issue(exe_pkg::OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 5'd0);
        issue(exe_pkg::OP_SLT,  32'h0000_0001, 32'hffff_ffff, 5'd0);
        issue(exe_pkg::OP_SLTU, 32'h0000_0001, 32'hffff_ffff, 5'd0);
        issue(exe_pkg::OP_SLT,  32'h8000_0000, 32'h7fff_ffff, 5'd0);
        issue(exe_pkg::OP_SLT,  32'h1234_5678, 32'h1234_5678, 5'd0);
        issue(exe_pkg::OP_SLTU, 32'h1234_5678, 32'h1234_5678, 5'd0);
        drain;
    endtask

    task automatic test_fixed_shifts;
        exe_pkg::exe_op_e ops[5];
        logic [4:0]       amounts[4];
        logic [W-1:0]     patterns[2];
        ops      = '{exe_pkg::OP_SLL, exe_pkg::OP_SRL, exe_pkg::OP_SRA,
                     exe_pkg::OP_ROTR, exe_pkg::OP_ROTL};
        amounts  = '{5'd0, 5'd1, 5'd16, 5'd31};
        patterns = '{32'h8765_4321, 32'h1234_5679};  // Top bit set and clear
        foreach (ops[i])
            foreach (amounts[j])
                foreach (patterns[k])
                    issue(ops[i], patterns[k], '0, amounts[j]);
        drain;
    endtask

    task automatic test_signed_amounts;
        exe_pkg::exe_op_e ops[3];
        logic [4:0]       amounts[4];
        logic [W-1:0]     patterns[2];
        ops      = '{exe_pkg::OP_SHV, exe_pkg::OP_SHAV, exe_pkg::OP_ROTV};
        amounts  = '{5'd3, 5'h1d, 5'd0, 5'h10};  // +3, -3, 0, -16
        patterns = '{32'hc001_d00d, 32'h5a5a_0ff1};
        foreach (ops[i])
            foreach (amounts[j])
                foreach (patterns[k])
                    issue(ops[i], patterns[k], '0, amounts[j]);
        issue(exe_pkg::OP_ROTR, 32'hc001_d00d, '0, 5'd29);  // Same as ROTV by -3
        issue(exe_pkg::OP_ROTL, 32'hc001_d00d, '0, 5'd16);  // Same as ROTV by -16
        drain;
    endtask

    task automatic test_stall;
        exe_pkg::exe_rsp_t held;
        int                start_count;
        start_count = rsp_count;
        for (int i = 0; i < 4; i++)
            issue(exe_pkg::OP_ADD, 32'h100 * (i + 1), 32'h11, 5'd0);
        // Freeze with two requests in flight and one offered
        cke        = 1'b0;
        in_valid   = 1'b1;
        req.src_a  = 32'hdead_beef;
        held       = expect_q[0];  // Third request sits in the output stage
        repeat (5) begin
            @(posedge clk);
            #1;
            check_value("rsp.result in stall", rsp.result, held.result);
            check_value("rsp.tag in stall", W'(rsp.tag), W'(held.tag));
            check_value("out_valid in stall", W'(out_valid), W'(1));
        end
        for (int i = 0; i < 4; i++)
            issue(exe_pkg::OP_XOR, 32'h5555_0000 + i, 32'h0f0f_0f0f, 5'd0);
        drain;
        check_value("responses through stall", rsp_count - start_count, 8);
    endtask

    task automatic test_random;
        logic [31:0]      bits;
        exe_pkg::exe_op_e op;
        logic [W-1:0]     a;
        logic [W-1:0]     b;
        logic [4:0]       amount;
        for (int i = 0; i < 200; i++) begin
            bits   = rand_bits(4);
            op     = exe_pkg::exe_op_e'(bits[3:0]);
            a      = rand_bits(32);
            b      = rand_bits(32);
            bits   = rand_bits(5);
            amount = bits[4:0];
            issue(op, a, b, amount);
            bits = rand_bits(3);
            if (bits[2])
                idle_cycles(1 + int'(bits[1:0]));  // Random gap in in_valid
        end
        drain;
    endtask

    initial begin
        reset      = 1'b1;
        cke        = 1'b1;
        in_valid   = 1'b0;
        req        = '0;
        lfsr_state = 32'd41;
        next_tag   = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset;
        test_arith;
        test_fixed_shifts;
        test_signed_amounts;
        test_stall;
        test_random;

        $display("Summary: %0d checks, %0d responses, %0d errors, %0d assertion failures",
                 check_count, rsp_count, error_count, dut.u_properties.fail_count);
        if (error_count == 0 && dut.u_properties.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/exe_pkg.sv
rtl/exe_shift.sv
rtl/exe_arith.sv
rtl/exe_op_decode.sv
rtl/exe_unit.sv
sim/exe_unit_properties.sv
sim/exe_unit_tb.sv
